/* verification/fetch_patterns.txt */
// hex values; first value is the test count
// per test: word count, addr word pairs, entry pc, bundle count, pc word pairs
3
// straight-line code
5
100 8b020020
104 d2800020
108 aa0103e0
10c 91000421
110 00000000
100
4
100 8b020020
104 d2800020
108 aa0103e0
10c 91000421
// b, bl, b.cond back, cbz forward, ret, b back onto the halt word
8
200 14000004
210 94000008
230 54fffec0
208 b4000200
248 d65f03c0
24c 91000421
250 17fffff4
220 00000000
200
7
200 14000004
210 94000008
230 54fffec0
208 b4000200
248 d65f03c0
24c 91000421
250 17fffff4
// new entry, cbnz and b.ne forward, bl back to address zero
4
80 35000042
88 54000041
90 97ffffdc
0 00000000
80
3
80 35000042
88 54000041
90 97ffffdc

/* fetch_core.f */
source/fetch_pkg.sv
source/insn_mem.sv
source/insn_decode.sv
source/fetch.sv
source/fetch_top.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fetch testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -Wno-fatal \
  --top-module fetch_tb \
  -f fetch_core.f \
  -o fetch_tb_sim

# the simulator exits non-zero on a fatal error, keep its output either way
sim_out=$(./obj_dir/fetch_tb_sim 2>&1) || true
echo "$sim_out"

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* verification/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

  logic                     in_clk;
  logic                     in_rst;
  fetch_pkg::axil_wreq_t    axil_req;
  fetch_pkg::axil_wrsp_t    axil_rsp;
  logic                     run;
  logic [63:0]              entry_pc;
  fetch_pkg::fetch_bundle_t bundle;
  logic                     bundle_valid;
  logic                     bundle_ready;
  logic                     halted;

  // flat image of the patterns file and a read cursor into it
  logic [63:0] pat [128];
  int          pat_pos;
  int          seed;

  // current test, program image and expected stream
  int          n_prog;
  logic [31:0] prog_addr [16];
  logic [31:0] prog_word [16];
  logic [63:0] test_entry;
  int          n_exp;
  logic [63:0] exp_pc [16];
  logic [31:0] exp_word [16];

  fetch_top fetch_top_i (
    .in_clk       (in_clk),
    .in_rst       (in_rst),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .run          (run),
    .entry_pc     (entry_pc),
    .bundle       (bundle),
    .bundle_valid (bundle_valid),
    .bundle_ready (bundle_ready),
    .halted       (halted)
  );

  // 4 ns period
  always #2 in_clk = ~in_clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compare_bundle(input string name, input fetch_pkg::fetch_bundle_t got,
                                input fetch_pkg::fetch_bundle_t exp);
    string got_str;
    string exp_str;
    if (got !== exp) begin
      got_str = $sformatf("insnbits=%h pc=%h opcode=%h pred_pc=%h",
                          got.insnbits, got.pc, got.opcode, got.pred_pc);
      exp_str = $sformatf("insnbits=%h pc=%h opcode=%h pred_pc=%h",
                          exp.insnbits, exp.pc, exp.opcode, exp.pred_pc);
      abort_run($sformatf("Mismatch %s: got %s, exp %s", name, got_str, exp_str));
    end
  endtask

  task automatic compare_bresp(input string name, input logic [1:0] got,
                               input logic [1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // expected bundle straight from the aarch64 encodings
  function automatic fetch_pkg::fetch_bundle_t expected_bundle(input logic [63:0] pc,
                                                               input logic [31:0] word);
    fetch_pkg::fetch_bundle_t exp;
    logic [63:0]              offset;
    logic                     taken;
    offset = 64'd0;
    taken = 1'b1;
    exp.insnbits = word;
    exp.pc = pc;
    if (word == 32'h0) begin
      exp.opcode = fetch_pkg::OP_NOP;
      taken = 1'b0;
    end else if ((word & 32'hfc000000) == 32'h14000000) begin
      exp.opcode = fetch_pkg::OP_B;
      offset = {{38{word[25]}}, word[25:0]} << 2;
    end else if ((word & 32'hfc000000) == 32'h94000000) begin
      exp.opcode = fetch_pkg::OP_BL;
      offset = {{38{word[25]}}, word[25:0]} << 2;
    end else if ((word & 32'hff000010) == 32'h54000000) begin
      exp.opcode = fetch_pkg::OP_B_COND;
      offset = {{45{word[23]}}, word[23:5]} << 2;
    end else if ((word & 32'h7e000000) == 32'h34000000) begin
      // cbz and cbnz in either width
      exp.opcode = fetch_pkg::OP_CBZ;
      offset = {{45{word[23]}}, word[23:5]} << 2;
    end else if ((word & 32'hfffffc1f) == 32'hd65f0000) begin
      exp.opcode = fetch_pkg::OP_RET;
      taken = 1'b0;
    end else begin
      exp.opcode = fetch_pkg::OP_OTHER;
      taken = 1'b0;
    end
    exp.pred_pc = taken ? pc + offset : pc + 64'd4;
    return exp;
  endfunction

  task automatic next_value(output logic [63:0] v);
    v = pat[pat_pos];
    pat_pos++;
  endtask

  // one write with its response checked one cycle after acceptance
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] exp_resp);
    int cycles;
    @(negedge in_clk);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr = addr;
    axil_req.wvalid = 1'b1;
    axil_req.wdata = data;
    axil_req.wstrb = strb;
    axil_req.bready = 1'b0;
    cycles = 0;
    #1;
    while (!(axil_rsp.awready && axil_rsp.wready)) begin
      if (cycles >= 20) abort_run("write address and data were never accepted");
      @(negedge in_clk);
      #1;
      cycles++;
    end
    // no response may be out yet in the accept cycle
    if (axil_rsp.bvalid) abort_run("write response came in the same cycle as acceptance");
    // accepted on the next rising edge
    @(negedge in_clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid = 1'b0;
    axil_req.bready = 1'b1;
    if (!axil_rsp.bvalid) abort_run("write response missing one cycle after acceptance");
    compare_bresp("axil_rsp.bresp", axil_rsp.bresp, exp_resp);
    @(negedge in_clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic load_test();
    logic [63:0] v;
    next_value(v);
    n_prog = int'(v[31:0]);
    for (int i = 0; i < n_prog; i++) begin
      next_value(v);
      prog_addr[i] = v[31:0];
      next_value(v);
      prog_word[i] = v[31:0];
      axil_write(prog_addr[i], prog_word[i], 4'hf, fetch_pkg::axil_resp_okay);
    end
    // two rejected writes that must leave the first word intact
    axil_write(prog_addr[0], ~prog_word[0], 4'h7, fetch_pkg::axil_resp_slverr);
    axil_write(prog_addr[0] | 32'h1000, ~prog_word[0], 4'hf, fetch_pkg::axil_resp_slverr);
    next_value(test_entry);
    next_value(v);
    n_exp = int'(v[31:0]);
    for (int i = 0; i < n_exp; i++) begin
      next_value(exp_pc[i]);
      next_value(v);
      exp_word[i] = v[31:0];
    end
  endtask

  // raise run and follow the stream up to the halt
  task automatic run_fetch(input logic stall);
    int          idx;
    int          cycles;
    logic [31:0] rand_word;
    @(negedge in_clk);
    entry_pc = test_entry;
    run = 1'b1;
    bundle_ready = 1'b1;
    idx = 0;
    cycles = 0;
    while (!(idx == n_exp && halted)) begin
      @(negedge in_clk);
      cycles++;
      if (cycles > 200) abort_run("fetch did not reach the halt word in time");
      rand_word = $random(seed);
      bundle_ready = stall ? rand_word[0] : 1'b1;
      if (bundle_valid && bundle_ready) begin
        if (idx >= n_exp) abort_run("a bundle transferred after the expected stream ended");
        compare_bundle("bundle", bundle, expected_bundle(exp_pc[idx], exp_word[idx]));
        idx++;
      end
    end
    // nothing else may show up while run stays high
    for (int i = 0; i < 4; i++) begin
      @(negedge in_clk);
      if (bundle_valid) abort_run("a bundle appeared while the stage was halted");
      if (!halted) abort_run("halted dropped while run was still high");
    end
  endtask

  task automatic stop_fetch();
    int cycles;
    @(negedge in_clk);
    run = 1'b0;
    bundle_ready = 1'b1;
    cycles = 0;
    while (halted || bundle_valid) begin
      if (cycles >= 20) abort_run("stage did not go idle after run fell");
      @(negedge in_clk);
      cycles++;
    end
  endtask

  initial begin
    logic [63:0] v;
    int          n_tests;
    seed = 32'h1166e8d5;
    in_clk = 1'b0;
    in_rst = 1'b1;
    axil_req = '0;
    run = 1'b0;
    entry_pc = 64'h0;
    bundle_ready = 1'b0;
    pat_pos = 0;
    $readmemh("verification/fetch_patterns.txt", pat);
    repeat (2) @(posedge in_clk);
    @(negedge in_clk);
    in_rst = 1'b0;
    next_value(v);
    n_tests = int'(v[31:0]);
    if (n_tests == 0) abort_run("the patterns file holds no tests");
    for (int t = 0; t < n_tests; t++) begin
      load_test();
      // same stream expected with and without back-pressure
      run_fetch(1'b0);
      stop_fetch();
      run_fetch(1'b1);
      stop_fetch();
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule : fetch_tb

/* verification/fetch_assertions.sv */
`timescale 1ns/1ps

module fetch_assertions (
  input logic                     in_clk,
  input logic                     in_rst,
  input fetch_pkg::fetch_bundle_t bundle,
  input logic                     bundle_valid,
  input logic                     bundle_ready,
  input logic                     halted
);

  // a stalled bundle keeps valid and payload
  property stall_holds;
    @(posedge in_clk) disable iff (in_rst)
      (bundle_valid && !bundle_ready) |=> (bundle_valid && $stable(bundle));
  endproperty

  // output slot is empty right after reset
  property empty_after_reset;
    @(posedge in_clk) in_rst |=> !bundle_valid;
  endproperty

  // the halt word produces no bundle
  property halt_no_bundle;
    @(posedge in_clk) disable iff (in_rst)
      halted |=> !bundle_valid;
  endproperty

  stall_holds_a : assert property (stall_holds)
    else $error("bundle changed while stalled");

  empty_after_reset_a : assert property (empty_after_reset)
    else $error("bundle_valid high after reset");

  halt_no_bundle_a : assert property (halt_no_bundle)
    else $error("bundle issued while halted");

endmodule : fetch_assertions

bind fetch fetch_assertions fetch_assertions_i (
  .in_clk       (in_clk),
  .in_rst       (in_rst),
  .bundle       (bundle),
  .bundle_valid (bundle_valid),
  .bundle_ready (bundle_ready),
  .halted       (halted)
);

/* source/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic                      in_clk,
  input  logic                      in_rst,
  input  fetch_pkg::axil_wreq_t     axil_req,
  output fetch_pkg::axil_wrsp_t     axil_rsp,
  input  logic                      run,
  input  logic [63:0]               entry_pc,
  output fetch_pkg::fetch_bundle_t  bundle,
  output logic                      bundle_valid,
  input  logic                      bundle_ready,
  output logic                      halted
);

  // fetch address and the word it selects
  logic [63:0]        pc;
  logic [31:0]        rdata;

  // classification of that word
  fetch_pkg::decode_t dec;

  // program storage, loaded by the host over the write channel
  insn_mem insn_mem_i (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .pc       (pc),
    .rdata    (rdata)
  );

  // opcode and branch offset for next-pc prediction
  insn_decode insn_decode_i (
    .insnbits (rdata),
    .dec      (dec)
  );

  // pc register and output bundle
  fetch fetch_i (
    .in_clk       (in_clk),
    .in_rst       (in_rst),
    .run          (run),
    .entry_pc     (entry_pc),
    .rdata        (rdata),
    .dec          (dec),
    .pc           (pc),
    .bundle       (bundle),
    .bundle_valid (bundle_valid),
    .bundle_ready (bundle_ready),
    .halted       (halted)
  );

endmodule : fetch_top

/* source/fetch.sv */
`timescale 1ns/1ps

module fetch (
  input  logic                      in_clk,
  input  logic                      in_rst,
  input  logic                      run,
  input  logic [63:0]               entry_pc,
  input  logic [31:0]               rdata,
  input  fetch_pkg::decode_t        dec,
  output logic [63:0]               pc,
  output fetch_pkg::fetch_bundle_t  bundle,
  output logic                      bundle_valid,
  input  logic                      bundle_ready,
  output logic                      halted
);

  // run from the previous cycle, for edge detection
  logic run_q;
  logic run_rise;

  // output register is free when empty or draining this edge
  logic out_free;

  // a fetch step happens on this edge
  logic step;
  logic word_zero;

  // prediction
  logic        pred_taken;
  logic [63:0] pred_pc;

  assign run_rise = run & ~run_q;
  assign out_free = ~bundle_valid | bundle_ready;

  // the edge that loads entry_pc does not fetch
  // once halted the pc sits on a zero word until run is cycled
  assign step = run & ~run_rise & out_free & ~halted;
  assign word_zero = (rdata == 32'h0);

  // direct branches are all guessed taken
  // ret and everything else fall through
  assign pred_taken = (dec.opcode == fetch_pkg::OP_B) |
                      (dec.opcode == fetch_pkg::OP_BL) |
                      (dec.opcode == fetch_pkg::OP_B_COND) |
                      (dec.opcode == fetch_pkg::OP_CBZ);

  assign pred_pc = pc + (pred_taken ? dec.imm : 64'd4);

  // pc, valid and halt state
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      run_q <= 1'b0;
      pc <= 64'h0;
      bundle_valid <= 1'b0;
      halted <= 1'b0;
    end else begin
      run_q <= run;

      // downstream took the bundle, slot empties unless refilled below
      if (bundle_valid && bundle_ready) begin
        bundle_valid <= 1'b0;
      end

      if (run_rise) begin
        pc <= entry_pc;
      end else if (step) begin
        if (word_zero) begin
          // pc holds on the empty word
          halted <= 1'b1;
        end else begin
          pc <= pred_pc;
          bundle_valid <= 1'b1;
        end
      end

      // stopping clears halt, a pending bundle still waits for ready
      if (!run) begin
        halted <= 1'b0;
      end
    end
  end

  // bundle payload, loaded only on a real instruction
  always_ff @(posedge in_clk) begin
    if (step && !word_zero) begin
      bundle.insnbits <= rdata;
      bundle.pc <= pc;
      bundle.opcode <= dec.opcode;
      bundle.pred_pc <= pred_pc;
    end
  end

endmodule : fetch

/* source/insn_decode.sv */
`timescale 1ns/1ps

module insn_decode (
  input  logic [31:0]         insnbits,
  output fetch_pkg::decode_t  dec
);

  // field matches for the branch families
  logic is_zero;
  logic is_b;
  logic is_bl;
  logic is_b_cond;
  logic is_cbz;
  logic is_ret;

  // the two immediate widths, scaled to byte offsets
  logic [63:0] imm26_off;
  logic [63:0] imm19_off;

  // all-zero word marks the end of the program
  assign is_zero = (insnbits == 32'h0);

  // b: 000101 imm26
  assign is_b = (insnbits[31:26] == 6'b000101);

  // bl: 100101 imm26
  assign is_bl = (insnbits[31:26] == 6'b100101);

  // b.cond: 01010100 imm19 0 cond
  assign is_b_cond = (insnbits[31:24] == 8'b01010100) & ~insnbits[4];

  // cbz and cbnz: sf 011010 op imm19 rt
  // sf and op are don't care here, both forms predict the same way
  assign is_cbz = (insnbits[30:25] == 6'b011010);

  // ret: 1101011 0010 11111 000000 rn 00000
  assign is_ret = (insnbits[31:10] == 22'b1101011001011111000000) &
                  (insnbits[4:0] == 5'b00000);

  // imm26 sits in [25:0], sign bit is 25
  assign imm26_off = {{36{insnbits[25]}}, insnbits[25:0], 2'b00};

  // imm19 sits in [23:5], sign bit is 23
  assign imm19_off = {{43{insnbits[23]}}, insnbits[23:5], 2'b00};

  // class select
  // zero word is checked first, it would otherwise not match anything
  always_comb begin
    if (is_zero) begin
      dec.opcode = fetch_pkg::OP_NOP;
    end else if (is_b) begin
      dec.opcode = fetch_pkg::OP_B;
    end else if (is_bl) begin
      dec.opcode = fetch_pkg::OP_BL;
    end else if (is_b_cond) begin
      dec.opcode = fetch_pkg::OP_B_COND;
    end else if (is_cbz) begin
      dec.opcode = fetch_pkg::OP_CBZ;
    end else if (is_ret) begin
      dec.opcode = fetch_pkg::OP_RET;
    end else begin
      dec.opcode = fetch_pkg::OP_OTHER;
    end
  end

  // offset select
  // ret jumps through a register, so it carries no immediate
  always_comb begin
    case (dec.opcode)
      fetch_pkg::OP_B,
      fetch_pkg::OP_BL: begin
        dec.imm = imm26_off;
      end
      fetch_pkg::OP_B_COND,
      fetch_pkg::OP_CBZ: begin
        dec.imm = imm19_off;
      end
      default: begin
        dec.imm = 64'h0;
      end
    endcase
  end

endmodule : insn_decode

/* source/insn_mem.sv */
`timescale 1ns/1ps

module insn_mem (
  input  logic                   in_clk,
  input  logic                   in_rst,
  input  fetch_pkg::axil_wreq_t  axil_req,
  output fetch_pkg::axil_wrsp_t  axil_rsp,
  input  logic [63:0]            pc,
  output logic [31:0]            rdata
);

  // word storage, contents survive reset so a loaded program stays put
  logic [31:0] mem [fetch_pkg::imem_words];

  // write response state
  logic       bvalid_q;
  logic [1:0] bresp_q;

  // write side decode
  logic                                wr_accept;
  logic                                wr_in_range;
  logic                                wr_full_strobe;
  logic                                wr_ok;
  logic [fetch_pkg::imem_addr_bits-1:0] wr_index;

  // read side decode
  logic                                rd_in_range;
  logic [fetch_pkg::imem_addr_bits-1:0] rd_index;

  // address and data must arrive together
  // and the previous response must have been taken
  assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;

  // byte address, low two bits ignored
  assign wr_index = axil_req.awaddr[fetch_pkg::imem_addr_bits+1:2];
  assign wr_in_range = (axil_req.awaddr[31:fetch_pkg::imem_addr_bits+2] == '0);
  assign wr_full_strobe = &axil_req.wstrb;

  // only whole-word writes inside the array are stored
  assign wr_ok = wr_in_range & wr_full_strobe;

  // both readies go up in the accept cycle
  assign axil_rsp.awready = wr_accept;
  assign axil_rsp.wready = wr_accept;
  assign axil_rsp.bvalid = bvalid_q;
  assign axil_rsp.bresp = bresp_q;

  // storage write
  always_ff @(posedge in_clk) begin
    if (wr_accept && wr_ok) begin
      mem[wr_index] <= axil_req.wdata;
    end
  end

  // response channel
  // bvalid follows acceptance by one cycle and waits for bready
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      bvalid_q <= 1'b0;
      bresp_q <= fetch_pkg::axil_resp_okay;
    end else if (wr_accept) begin
      bvalid_q <= 1'b1;
      bresp_q <= wr_ok ? fetch_pkg::axil_resp_okay : fetch_pkg::axil_resp_slverr;
    end else if (bvalid_q && axil_req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // asynchronous read port
  // pc is a byte address, word index sits above the two alignment bits
  assign rd_index = pc[fetch_pkg::imem_addr_bits+1:2];
  assign rd_in_range = (pc[63:fetch_pkg::imem_addr_bits+2] == '0);

  // anything past the end of memory reads as a zero word, which halts fetch
  assign rdata = rd_in_range ? mem[rd_index] : 32'h0;

endmodule : insn_mem

/* source/fetch_pkg.sv */
package fetch_pkg;

  // instruction memory geometry, one 32-bit word per entry
  localparam int imem_words = 1024;
  localparam int imem_addr_bits = 10;

  // bresp codes for the write channel
  localparam logic [1:0] axil_resp_okay = 2'b00;
  localparam logic [1:0] axil_resp_slverr = 2'b10;

  // opcode classes the fetch stage cares about
  // everything that is not a branch or ret collapses to op_other
  typedef enum logic [2:0] {
    OP_NOP,
    OP_B,
    OP_BL,
    OP_B_COND,
    OP_CBZ,
    OP_RET,
    OP_OTHER
  } opcode_t;

  // decoder result
  // imm is a byte offset, already sign-extended and scaled by 4
  typedef struct packed {
    opcode_t     opcode;
    logic [63:0] imm;
  } decode_t;

  // what fetch hands to decode each cycle
  typedef struct packed {
    logic [31:0] insnbits;
    logic [63:0] pc;
    opcode_t     opcode;
    logic [63:0] pred_pc;
  } fetch_bundle_t;

  // host to memory, write address, write data and response ready
  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
  } axil_wreq_t;

  // memory to host
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axil_wrsp_t;

endpackage : fetch_pkg
